/* Makefile */
SRCS = rtl/rv32i_id_params.svh rtl/rv32i_pkg.sv rtl/instr_decoder.sv \
       rtl/operand_fetch.sv rtl/branch_unit.sv rtl/rv32i_id.sv \
       bench/id_model.svh bench/rv32i_id_tb.sv

.PHONY: all run clean

all: run

obj_dir/Vrv32i_id_tb: rv32i_id.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ns \
		--top-module rv32i_id_tb -f rv32i_id.f

run: obj_dir/Vrv32i_id_tb
	./obj_dir/Vrv32i_id_tb | tee sim.log
	grep -q '^STATUS: PASS$$' sim.log

clean:
	rm -rf obj_dir sim.log

/* bench/id_model.svh */
`ifndef ID_MODEL_SVH
`define ID_MODEL_SVH

// shadow register file and expected statistics
word_t shadow_rf [`NUM_REGS];
cnt_t  model_br_cnt;
cnt_t  model_jump_cnt;
cnt_t  model_mispred_cnt;

function automatic word_t imm_i_fmt(word_t ins);
    return {{20{ins[31]}}, ins[31:20]};
endfunction

function automatic word_t imm_s_fmt(word_t ins);
    return {{20{ins[31]}}, ins[31:25], ins[11:7]};
endfunction

function automatic word_t imm_b_fmt(word_t ins);
    return {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
endfunction

function automatic word_t imm_u_fmt(word_t ins);
    return {ins[31:12], 12'b0};
endfunction

function automatic word_t imm_j_fmt(word_t ins);
    return {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
endfunction

function automatic word_t select_imm(word_t ins);
    case (ins[6:0])
        op_lui, op_auipc:         return imm_u_fmt(ins);
        op_jal:                   return imm_j_fmt(ins);
        op_jalr, op_load, op_imm: return imm_i_fmt(ins);
        op_br:                    return imm_b_fmt(ins);
        op_store:                 return imm_s_fmt(ins);
        default:                  return '0;
    endcase
endfunction

// packed as load_rf, mem_rd, mem_wr, alu_imm, byte_en, wb_sel
function automatic logic [9:0] expect_ctrl(word_t ins, logic live);
    logic [5:0] ctl;
    logic [3:0] be;
    case (ins[6:0])
        op_lui:   ctl = {4'b1001, wb_imm};
        op_auipc: ctl = {4'b1001, wb_alu};
        op_jal:   ctl = {4'b1000, wb_pc4};
        op_jalr:  ctl = {4'b1001, wb_pc4};
        op_load:  ctl = {4'b1101, wb_mem};
        op_store: ctl = {4'b0011, wb_alu};
        op_imm:   ctl = {4'b1001, wb_alu};
        op_reg:   ctl = {4'b1000, wb_alu};
        default:  ctl = {4'b0000, wb_alu};
    endcase
    case (ins[13:12])
        2'b00:   be = 4'b0001;
        2'b01:   be = 4'b0011;
        default: be = 4'b1111;
    endcase
    if (!(ctl[4] || ctl[3])) begin
        be = 4'b0000;
    end
    return live ? {ctl[5:2], be, ctl[1:0]} : {8'h00, wb_alu};
endfunction

// register read with write-through, then the forwarding choice
function automatic word_t read_operand(reg_idx_t idx, fwd_src_t sel);
    word_t val;
    if (idx == 0) begin
        val = '0;
    end else if (wb_en && (wb_rd == idx)) begin
        val = wb_data;
    end else begin
        val = shadow_rf[idx];
    end
    case (sel)
        fwd_ex_alu:  val = ex_alu;
        fwd_mem_alu: val = mem_alu;
        fwd_mem_ld:  val = mem_ld;
        fwd_wb_alu:  val = wb_alu_v;
        fwd_wb_ld:   val = wb_ld;
        default:     ;
    endcase
    return val;
endfunction

function automatic logic branch_cond(logic [2:0] f3, word_t a, word_t b);
    case (f3)
        3'b000:  return a == b;
        3'b001:  return a != b;
        3'b100:  return $signed(a) < $signed(b);
        3'b101:  return $signed(a) >= $signed(b);
        3'b110:  return a < b;
        3'b111:  return a >= b;
        default: return 1'b0;
    endcase
endfunction

// without a live control-flow op the target is the next pc
function automatic word_t expect_target(word_t ins, logic live, word_t pc_v, word_t a);
    if (!live) begin
        return pc_v + 4;
    end
    case (ins[6:0])
        op_br:   return pc_v + imm_b_fmt(ins);
        op_jal:  return pc_v + imm_j_fmt(ins);
        op_jalr: return (a + imm_i_fmt(ins)) & 32'hffff_fffe;
        default: return pc_v + 4;
    endcase
endfunction

task automatic clear_model();
    for (int i = 0; i < `NUM_REGS; i++) begin
        shadow_rf[i] = '0;
    end
    model_br_cnt      = '0;
    model_jump_cnt    = '0;
    model_mispred_cnt = '0;
endtask

// same edge as the DUT register file
task automatic commit_writeback();
    if (wb_en && (wb_rd != 0)) begin
        shadow_rf[wb_rd] = wb_data;
    end
endtask

`endif

/* bench/rv32i_id_tb.sv */
`timescale 1ns/1ns
`include "rv32i_id_params.svh"

module rv32i_id_tb
    import rv32i_pkg::*;
();
    localparam int NUM_CYCLES   = 2000;
    localparam int RESET_CYCLES = 8;
    localparam int CYCLE_LIMIT  = NUM_CYCLES + RESET_CYCLES + 100;

    logic     clk;
    logic     rst;
    logic     instr_valid;
    word_t    instr;
    word_t    pc;
    logic     bubble;
    logic     stall;
    logic     pred_taken;
    logic     wb_en;
    reg_idx_t wb_rd;
    word_t    wb_data;
    fwd_src_t fwd_a_sel;
    fwd_src_t fwd_b_sel;
    word_t    ex_alu;
    word_t    mem_alu;
    word_t    mem_ld;
    word_t    wb_alu_v;
    word_t    wb_ld;

    opcode_t    dut_opcode;
    logic [2:0] dut_funct3;
    reg_idx_t   dut_rs1;
    reg_idx_t   dut_rs2;
    reg_idx_t   dut_rd;
    word_t      dut_imm;
    logic       dut_load_rf;
    logic       dut_mem_rd;
    logic       dut_mem_wr;
    logic [3:0] dut_byte_en;
    logic       dut_alu_imm;
    wb_sel_t    dut_wb_sel;
    word_t      dut_rs1_val;
    word_t      dut_rs2_val;
    logic       dut_taken;
    word_t      dut_target;
    logic       dut_redirect;
    logic       dut_flush;
    logic       dut_halt;
    cnt_t       dut_br_cnt;
    cnt_t       dut_jump_cnt;
    cnt_t       dut_mispred_cnt;

    int mismatches = 0;
    int checked = 0;
    int cycle_count = 0;

    opcode_t op_set [9] = '{op_lui, op_auipc, op_jal, op_jalr, op_br,
                            op_load, op_store, op_imm, op_reg};

    `include "id_model.svh"

    rv32i_id dut_i (
        .clk             (clk),
        .rst             (rst),
        .instr_valid_i   (instr_valid),
        .instr_i         (instr),
        .pc_i            (pc),
        .bubble_i        (bubble),
        .stall_i         (stall),
        .pred_taken_i    (pred_taken),
        .wb_en_i         (wb_en),
        .wb_rd_i         (wb_rd),
        .wb_data_i       (wb_data),
        .fwd_a_sel_i     (fwd_a_sel),
        .fwd_b_sel_i     (fwd_b_sel),
        .ex_alu_i        (ex_alu),
        .mem_alu_i       (mem_alu),
        .mem_ld_i        (mem_ld),
        .wb_alu_i        (wb_alu_v),
        .wb_ld_i         (wb_ld),
        .opcode_o        (dut_opcode),
        .funct3_o        (dut_funct3),
        .rs1_o           (dut_rs1),
        .rs2_o           (dut_rs2),
        .rd_o            (dut_rd),
        .imm_o           (dut_imm),
        .load_regfile_o  (dut_load_rf),
        .mem_read_o      (dut_mem_rd),
        .mem_write_o     (dut_mem_wr),
        .mem_byte_en_o   (dut_byte_en),
        .alu_imm_sel_o   (dut_alu_imm),
        .wb_sel_o        (dut_wb_sel),
        .rs1_val_o       (dut_rs1_val),
        .rs2_val_o       (dut_rs2_val),
        .br_taken_o      (dut_taken),
        .target_o        (dut_target),
        .redirect_o      (dut_redirect),
        .flush_o         (dut_flush),
        .halt_o          (dut_halt),
        .br_count_o      (dut_br_cnt),
        .jump_count_o    (dut_jump_cnt),
        .mispred_count_o (dut_mispred_cnt)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // stop a stuck run at the cycle limit
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    function automatic void note_mismatch(string what, word_t got, word_t exp);
        $display("MISMATCH at %0t: %s got %h, expected %h", $time, what, got, exp);
        mismatches++;
    endfunction

    task automatic draw_instr(output word_t ins);
        ins      = $urandom;
        ins[6:0] = op_set[$urandom_range(8)];
        // now and then a zero offset, so jal and branches can target themselves
        if ($urandom_range(7) == 0) begin
            if (ins[6:0] == op_jal) begin
                ins[31:12] = '0;
            end else if (ins[6:0] == op_br) begin
                ins[31:25] = '0;
                ins[11:7]  = '0;
            end
        end
    endtask

    task automatic drive_random();
        word_t ins;
        word_t pc_v;
        draw_instr(ins);
        pc_v = $urandom & 32'hffff_fffc;
        // a self-target at pc zero must not halt
        if ($urandom_range(3) == 0) begin
            pc_v = '0;
        end
        instr_valid <= ($urandom_range(7) != 0);
        instr       <= ins;
        pc          <= pc_v;
        bubble      <= ($urandom_range(19) == 0);
        stall       <= ($urandom_range(19) == 0);
        pred_taken  <= 1'($urandom);
        wb_en       <= ($urandom_range(3) != 0);
        wb_rd       <= reg_idx_t'($urandom);
        wb_data     <= $urandom;
        // register file source about half the time
        fwd_a_sel   <= $urandom_range(1) ? fwd_rf : fwd_src_t'(3'($urandom_range(5)));
        fwd_b_sel   <= $urandom_range(1) ? fwd_rf : fwd_src_t'(3'($urandom_range(5)));
        ex_alu      <= $urandom;
        mem_alu     <= $urandom;
        mem_ld      <= $urandom;
        wb_alu_v    <= $urandom;
        wb_ld       <= $urandom;
    endtask

    task automatic check_reset_state();
        assert (dut_halt == 1'b0) else note_mismatch("halt in reset", dut_halt, 0);
        assert (dut_br_cnt == 0) else note_mismatch("br_count in reset", dut_br_cnt, 0);
        assert (dut_jump_cnt == 0) else note_mismatch("jump_count in reset", dut_jump_cnt, 0);
        assert (dut_mispred_cnt == 0)
            else note_mismatch("mispred_count in reset", dut_mispred_cnt, 0);
    endtask

    task automatic check_outputs();
        logic       live;
        logic       is_br;
        logic       is_jump;
        logic       exp_taken;
        logic       exp_redirect;
        logic       exp_halt;
        logic [9:0] exp_ctrl;
        word_t      exp_a;
        word_t      exp_b;
        word_t      exp_target;
        live         = instr_valid && !bubble && !stall;
        exp_a        = read_operand(instr[19:15], fwd_a_sel);
        exp_b        = read_operand(instr[24:20], fwd_b_sel);
        exp_ctrl     = expect_ctrl(instr, live);
        is_br        = live && (instr[6:0] == op_br);
        is_jump      = live && ((instr[6:0] == op_jal) || (instr[6:0] == op_jalr));
        exp_taken    = is_br && branch_cond(instr[14:12], exp_a, exp_b);
        exp_redirect = exp_taken || is_jump;
        exp_target   = expect_target(instr, live, pc, exp_a);
        exp_halt     = exp_redirect && (exp_target == pc) && (pc != 0);

        assert (dut_opcode == (live ? instr[6:0] : 7'h00))
            else note_mismatch("opcode", dut_opcode, live ? instr[6:0] : 7'h00);
        assert ({dut_funct3, dut_rs1, dut_rs2, dut_rd} ==
                {instr[14:12], instr[19:15], instr[24:20], instr[11:7]})
            else note_mismatch("fields", {dut_funct3, dut_rs1, dut_rs2, dut_rd},
                               {instr[14:12], instr[19:15], instr[24:20], instr[11:7]});
        assert (dut_imm == select_imm(instr)) else note_mismatch("imm", dut_imm, select_imm(instr));
        assert ({dut_load_rf, dut_mem_rd, dut_mem_wr, dut_alu_imm, dut_byte_en, dut_wb_sel}
                == exp_ctrl)
            else note_mismatch("control", {dut_load_rf, dut_mem_rd, dut_mem_wr, dut_alu_imm,
                                           dut_byte_en, dut_wb_sel}, exp_ctrl);
        assert (dut_rs1_val == exp_a) else note_mismatch("rs1_val", dut_rs1_val, exp_a);
        assert (dut_rs2_val == exp_b) else note_mismatch("rs2_val", dut_rs2_val, exp_b);
        assert (dut_taken == exp_taken) else note_mismatch("br_taken", dut_taken, exp_taken);
        assert (dut_target == exp_target) else note_mismatch("target", dut_target, exp_target);
        assert (dut_redirect == exp_redirect)
            else note_mismatch("redirect", dut_redirect, exp_redirect);
        assert (dut_flush == (exp_redirect && !stall))
            else note_mismatch("flush", dut_flush, exp_redirect && !stall);
        assert (dut_halt == exp_halt) else note_mismatch("halt", dut_halt, exp_halt);
        assert (dut_br_cnt == model_br_cnt)
            else note_mismatch("br_count", dut_br_cnt, model_br_cnt);
        assert (dut_jump_cnt == model_jump_cnt)
            else note_mismatch("jump_count", dut_jump_cnt, model_jump_cnt);
        assert (dut_mispred_cnt == model_mispred_cnt)
            else note_mismatch("mispred_count", dut_mispred_cnt, model_mispred_cnt);

        // counts of this cycle show after the next edge
        if (is_br) begin
            model_br_cnt++;
        end
        if (is_jump) begin
            model_jump_cnt++;
        end
        if (is_br && (exp_taken != pred_taken)) begin
            model_mispred_cnt++;
        end
        commit_writeback();
        checked++;
    endtask

    initial begin
        void'($urandom(32'hcf82));
        clear_model();
        // a live self-targeting jal while reset is held
        rst         = 1'b1;
        instr_valid = 1'b1;
        instr       = 32'h0000_006f;
        pc          = 32'h0000_0100;
        bubble      = 1'b0;
        stall       = 1'b0;
        pred_taken  = 1'b0;
        wb_en       = 1'b0;
        wb_rd       = '0;
        wb_data     = '0;
        fwd_a_sel   = fwd_rf;
        fwd_b_sel   = fwd_rf;
        ex_alu      = '0;
        mem_alu     = '0;
        mem_ld      = '0;
        wb_alu_v    = '0;
        wb_ld       = '0;
        repeat (RESET_CYCLES / 2) @(posedge clk);
        @(negedge clk);
        check_reset_state();
        repeat (RESET_CYCLES / 2) @(posedge clk);
        rst <= 1'b0;
        for (int n = 0; n < NUM_CYCLES; n++) begin
            drive_random();
            @(negedge clk);
            check_outputs();
            @(posedge clk);
        end
        $display("cycles checked: %0d, mismatches: %0d", checked, mismatches);
        if (mismatches == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

/* rtl/branch_unit.sv */
`timescale 1ns/1ns

module branch_unit
    import rv32i_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       ctrl_live_i,
    input  opcode_t    opcode_i,
    input  logic [2:0] funct3_i,
    input  word_t      pc_i,
    input  word_t      rs1_val_i,
    input  word_t      rs2_val_i,
    input  word_t      b_imm_i,
    input  word_t      i_imm_i,
    input  word_t      j_imm_i,
    input  logic       pred_taken_i,
    input  logic       stall_i,
    output logic       br_taken_o,
    output word_t      target_o,
    output logic       redirect_o,
    output logic       flush_o,
    output logic       halt_o,
    output cnt_t       br_count_o,
    output cnt_t       jump_count_o,
    output cnt_t       mispred_count_o
);
    logic  is_br;
    logic  is_jump;
    logic  cmp_true;
    word_t jalr_sum;

    assign is_br   = ctrl_live_i && (opcode_i == op_br);
    assign is_jump = ctrl_live_i && ((opcode_i == op_jal) || (opcode_i == op_jalr));

    always_comb begin
        case (br_funct3_t'(funct3_i))
            beq:     cmp_true = (rs1_val_i == rs2_val_i);
            bne:     cmp_true = (rs1_val_i != rs2_val_i);
            blt:     cmp_true = ($signed(rs1_val_i) < $signed(rs2_val_i));
            bge:     cmp_true = ($signed(rs1_val_i) >= $signed(rs2_val_i));
            bltu:    cmp_true = (rs1_val_i < rs2_val_i);
            bgeu:    cmp_true = (rs1_val_i >= rs2_val_i);
            default: cmp_true = 1'b0;
        endcase
    end

    assign jalr_sum = rs1_val_i + i_imm_i;

    // non-control instructions fall through to pc + 4
    always_comb begin
        case (opcode_i)
            op_br:   target_o = pc_i + b_imm_i;
            op_jal:  target_o = pc_i + j_imm_i;
            op_jalr: target_o = {jalr_sum[31:1], 1'b0};
            default: target_o = pc_i + 32'd4;
        endcase
    end

    assign br_taken_o = is_br & cmp_true;
    assign redirect_o = br_taken_o | is_jump;

    // target only known here, so every redirect flushes the fetched slot
    assign flush_o = redirect_o & ~stall_i;

    // a jump onto itself ends the program
    assign halt_o = redirect_o & (target_o == pc_i) & (pc_i != '0) & ~rst;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            br_count_o      <= '0;
            jump_count_o    <= '0;
            mispred_count_o <= '0;
        end else begin
            if (is_br) begin
                br_count_o <= br_count_o + 1'b1;
            end
            if (is_jump) begin
                jump_count_o <= jump_count_o + 1'b1;
            end
            if (is_br && (cmp_true != pred_taken_i)) begin
                mispred_count_o <= mispred_count_o + 1'b1;
            end
        end
    end

endmodule

/* rtl/instr_decoder.sv */
`timescale 1ns/1ns

module instr_decoder
    import rv32i_pkg::*;
(
    input  logic       instr_valid_i,
    input  word_t      instr_i,
    input  logic       bubble_i,
    input  logic       stall_i,
    output opcode_t    opcode_o,
    output logic [2:0] funct3_o,
    output reg_idx_t   rs1_o,
    output reg_idx_t   rs2_o,
    output reg_idx_t   rd_o,
    output word_t      imm_o,
    output word_t      b_imm_o,
    output word_t      i_imm_o,
    output word_t      j_imm_o,
    output logic       ctrl_live_o,
    output logic       load_regfile_o,
    output logic       mem_read_o,
    output logic       mem_write_o,
    output logic [3:0] mem_byte_en_o,
    output logic       alu_imm_sel_o,
    output wb_sel_t    wb_sel_o
);
    word_t      s_imm;
    word_t      u_imm;
    logic       legal;
    logic       dec_load_rf;
    logic       dec_mem_rd;
    logic       dec_mem_wr;
    logic       dec_alu_imm;
    logic [3:0] dec_byte_en;
    wb_sel_t    dec_wb_sel;

    assign funct3_o = instr_i[14:12];
    assign rs1_o    = instr_i[19:15];
    assign rs2_o    = instr_i[24:20];
    assign rd_o     = instr_i[11:7];

    // sign-extended immediates, one per format
    assign i_imm_o = {{21{instr_i[31]}}, instr_i[30:20]};
    assign s_imm   = {{21{instr_i[31]}}, instr_i[30:25], instr_i[11:7]};
    assign b_imm_o = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
    assign u_imm   = {instr_i[31:12], 12'h000};
    assign j_imm_o = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};

    always_comb begin
        legal       = 1'b1;
        dec_load_rf = 1'b0;
        dec_mem_rd  = 1'b0;
        dec_mem_wr  = 1'b0;
        dec_alu_imm = 1'b0;
        dec_wb_sel  = wb_alu;
        imm_o       = '0;
        case (instr_i[6:0])
            op_lui: begin
                dec_load_rf = 1'b1;
                dec_alu_imm = 1'b1;
                dec_wb_sel  = wb_imm;
                imm_o       = u_imm;
            end
            op_auipc: begin
                dec_load_rf = 1'b1;
                dec_alu_imm = 1'b1;
                imm_o       = u_imm;
            end
            op_jal: begin
                dec_load_rf = 1'b1;
                dec_wb_sel  = wb_pc4;
                imm_o       = j_imm_o;
            end
            op_jalr: begin
                dec_load_rf = 1'b1;
                dec_alu_imm = 1'b1;
                dec_wb_sel  = wb_pc4;
                imm_o       = i_imm_o;
            end
            op_br:    imm_o = b_imm_o;
            op_load: begin
                dec_load_rf = 1'b1;
                dec_mem_rd  = 1'b1;
                dec_alu_imm = 1'b1;
                dec_wb_sel  = wb_mem;
                imm_o       = i_imm_o;
            end
            op_store: begin
                dec_mem_wr  = 1'b1;
                dec_alu_imm = 1'b1;
                imm_o       = s_imm;
            end
            op_imm: begin
                dec_load_rf = 1'b1;
                dec_alu_imm = 1'b1;
                imm_o       = i_imm_o;
            end
            op_reg:   dec_load_rf = 1'b1;
            default:  legal = 1'b0;
        endcase
    end

    // access size from funct3, only for loads and stores
    always_comb begin
        case (instr_i[13:12])
            2'b00:   dec_byte_en = 4'b0001;
            2'b01:   dec_byte_en = 4'b0011;
            default: dec_byte_en = 4'b1111;
        endcase
        if (!(dec_mem_rd || dec_mem_wr)) begin
            dec_byte_en = 4'b0000;
        end
    end

    // bubble when no strobe, hazard bubble or stall
    assign ctrl_live_o    = instr_valid_i & ~bubble_i & ~stall_i & legal;
    assign opcode_o       = ctrl_live_o ? opcode_t'(instr_i[6:0]) : op_none;
    assign load_regfile_o = ctrl_live_o & dec_load_rf;
    assign mem_read_o     = ctrl_live_o & dec_mem_rd;
    assign mem_write_o    = ctrl_live_o & dec_mem_wr;
    assign mem_byte_en_o  = ctrl_live_o ? dec_byte_en : 4'b0000;
    assign alu_imm_sel_o  = ctrl_live_o & dec_alu_imm;
    assign wb_sel_o       = ctrl_live_o ? dec_wb_sel : wb_alu;

endmodule

/* rtl/operand_fetch.sv */
`timescale 1ns/1ns
`include "rv32i_id_params.svh"

module operand_fetch
    import rv32i_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  reg_idx_t rs1_i,
    input  reg_idx_t rs2_i,
    input  logic     wb_en_i,
    input  reg_idx_t wb_rd_i,
    input  word_t    wb_data_i,
    input  fwd_src_t fwd_a_sel_i,
    input  fwd_src_t fwd_b_sel_i,
    input  word_t    ex_alu_i,
    input  word_t    mem_alu_i,
    input  word_t    mem_ld_i,
    input  word_t    wb_alu_i,
    input  word_t    wb_ld_i,
    output word_t    rs1_val_o,
    output word_t    rs2_val_o
);
    word_t regs [`NUM_REGS];

    // x0 is never written
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en_i && (wb_rd_i != '0)) begin
            regs[wb_rd_i] <= wb_data_i;
        end
    end

    // read with write-through of the pending writeback
    function automatic word_t rf_read(input reg_idx_t idx);
        word_t val;
        if (idx == '0) begin
            val = '0;
        end else if (wb_en_i && (wb_rd_i == idx)) begin
            val = wb_data_i;
        end else begin
            val = regs[idx];
        end
        return val;
    endfunction

    function automatic word_t fwd_pick(input fwd_src_t sel, input word_t rf_val);
        word_t val;
        case (sel)
            fwd_ex_alu:  val = ex_alu_i;
            fwd_mem_alu: val = mem_alu_i;
            fwd_mem_ld:  val = mem_ld_i;
            fwd_wb_alu:  val = wb_alu_i;
            fwd_wb_ld:   val = wb_ld_i;
            default:     val = rf_val;
        endcase
        return val;
    endfunction

    always_comb begin
        rs1_val_o = fwd_pick(fwd_a_sel_i, rf_read(rs1_i));
        rs2_val_o = fwd_pick(fwd_b_sel_i, rf_read(rs2_i));
    end

endmodule

/* rtl/rv32i_id.sv */
`timescale 1ns/1ns

module rv32i_id
    import rv32i_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       instr_valid_i,
    input  word_t      instr_i,
    input  word_t      pc_i,
    input  logic       bubble_i,
    input  logic       stall_i,
    input  logic       pred_taken_i,
    input  logic       wb_en_i,
    input  reg_idx_t   wb_rd_i,
    input  word_t      wb_data_i,
    input  fwd_src_t   fwd_a_sel_i,
    input  fwd_src_t   fwd_b_sel_i,
    input  word_t      ex_alu_i,
    input  word_t      mem_alu_i,
    input  word_t      mem_ld_i,
    input  word_t      wb_alu_i,
    input  word_t      wb_ld_i,
    output opcode_t    opcode_o,
    output logic [2:0] funct3_o,
    output reg_idx_t   rs1_o,
    output reg_idx_t   rs2_o,
    output reg_idx_t   rd_o,
    output word_t      imm_o,
    output logic       load_regfile_o,
    output logic       mem_read_o,
    output logic       mem_write_o,
    output logic [3:0] mem_byte_en_o,
    output logic       alu_imm_sel_o,
    output wb_sel_t    wb_sel_o,
    output word_t      rs1_val_o,
    output word_t      rs2_val_o,
    output logic       br_taken_o,
    output word_t      target_o,
    output logic       redirect_o,
    output logic       flush_o,
    output logic       halt_o,
    output cnt_t       br_count_o,
    output cnt_t       jump_count_o,
    output cnt_t       mispred_count_o
);
    reg_idx_t   rs1_idx;
    reg_idx_t   rs2_idx;
    opcode_t    opcode;
    logic [2:0] funct3;
    word_t      b_imm;
    word_t      i_imm;
    word_t      j_imm;
    logic       ctrl_live;
    word_t      rs1_val;
    word_t      rs2_val;

    assign opcode_o  = opcode;
    assign funct3_o  = funct3;
    assign rs1_o     = rs1_idx;
    assign rs2_o     = rs2_idx;
    assign rs1_val_o = rs1_val;
    assign rs2_val_o = rs2_val;

    instr_decoder u_decoder (
        .instr_valid_i  (instr_valid_i),
        .instr_i        (instr_i),
        .bubble_i       (bubble_i),
        .stall_i        (stall_i),
        .opcode_o       (opcode),
        .funct3_o       (funct3),
        .rs1_o          (rs1_idx),
        .rs2_o          (rs2_idx),
        .rd_o           (rd_o),
        .imm_o          (imm_o),
        .b_imm_o        (b_imm),
        .i_imm_o        (i_imm),
        .j_imm_o        (j_imm),
        .ctrl_live_o    (ctrl_live),
        .load_regfile_o (load_regfile_o),
        .mem_read_o     (mem_read_o),
        .mem_write_o    (mem_write_o),
        .mem_byte_en_o  (mem_byte_en_o),
        .alu_imm_sel_o  (alu_imm_sel_o),
        .wb_sel_o       (wb_sel_o)
    );

    operand_fetch u_operands (
        .clk         (clk),
        .rst         (rst),
        .rs1_i       (rs1_idx),
        .rs2_i       (rs2_idx),
        .wb_en_i     (wb_en_i),
        .wb_rd_i     (wb_rd_i),
        .wb_data_i   (wb_data_i),
        .fwd_a_sel_i (fwd_a_sel_i),
        .fwd_b_sel_i (fwd_b_sel_i),
        .ex_alu_i    (ex_alu_i),
        .mem_alu_i   (mem_alu_i),
        .mem_ld_i    (mem_ld_i),
        .wb_alu_i    (wb_alu_i),
        .wb_ld_i     (wb_ld_i),
        .rs1_val_o   (rs1_val),
        .rs2_val_o   (rs2_val)
    );

    branch_unit u_branch (
        .clk             (clk),
        .rst             (rst),
        .ctrl_live_i     (ctrl_live),
        .opcode_i        (opcode),
        .funct3_i        (funct3),
        .pc_i            (pc_i),
        .rs1_val_i       (rs1_val),
        .rs2_val_i       (rs2_val),
        .b_imm_i         (b_imm),
        .i_imm_i         (i_imm),
        .j_imm_i         (j_imm),
        .pred_taken_i    (pred_taken_i),
        .stall_i         (stall_i),
        .br_taken_o      (br_taken_o),
        .target_o        (target_o),
        .redirect_o      (redirect_o),
        .flush_o         (flush_o),
        .halt_o          (halt_o),
        .br_count_o      (br_count_o),
        .jump_count_o    (jump_count_o),
        .mispred_count_o (mispred_count_o)
    );

endmodule

/* rtl/rv32i_id_params.svh */
`ifndef RV32I_ID_PARAMS_SVH
`define RV32I_ID_PARAMS_SVH

// data path and address width
`define XLEN 32

// architectural registers, x0 included
`define NUM_REGS 32

// width of the control-flow statistics counters
`define CNT_W 16

`endif

/* rtl/rv32i_pkg.sv */
`include "rv32i_id_params.svh"

package rv32i_pkg;

    // one data word, pc or immediate
    typedef logic [`XLEN-1:0] word_t;

    typedef logic [4:0] reg_idx_t;

    typedef logic [`CNT_W-1:0] cnt_t;

    // base opcodes, zero marks a bubble
    typedef enum logic [6:0] {
        op_none  = 7'b0000000,
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_br    = 7'b1100011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011
    } opcode_t;

    typedef enum logic [2:0] {
        beq  = 3'b000,
        bne  = 3'b001,
        blt  = 3'b100,
        bge  = 3'b101,
        bltu = 3'b110,
        bgeu = 3'b111
    } br_funct3_t;

    // operand source, register file or a later stage
    typedef enum logic [2:0] {
        fwd_rf      = 3'd0,
        fwd_ex_alu  = 3'd1,
        fwd_mem_alu = 3'd2,
        fwd_mem_ld  = 3'd3,
        fwd_wb_alu  = 3'd4,
        fwd_wb_ld   = 3'd5
    } fwd_src_t;

    typedef enum logic [1:0] {
        wb_alu = 2'd0,
        wb_mem = 2'd1,
        wb_pc4 = 2'd2,
        wb_imm = 2'd3
    } wb_sel_t;

endpackage

/* rv32i_id.f */
+incdir+rtl
+incdir+bench
rtl/rv32i_pkg.sv
rtl/instr_decoder.sv
rtl/operand_fetch.sv
rtl/branch_unit.sv
rtl/rv32i_id.sv
bench/rv32i_id_tb.sv
